/* dv/backend_tb.sv */
`include "core_defines.svh"

module backend_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'he32bb5fd;
    localparam int DRAIN_LIMIT  = 200;
    localparam int HALT_LIMIT   = 50;
    localparam int QUIET_CYCLES = 20;

    logic     clock;
    logic     reset;
    logic     in_valid;
    op_e      in_op;
    reg_idx_t in_dest;
    word_t    in_a;
    word_t    in_b;
    word_t    in_pc;
    logic     in_predicted_taken;
    reg_idx_t read_addr;
    logic     rob_full;
    logic     squash;
    word_t    redirect_pc;
    logic     halt;
    logic     retire_valid_0;
    reg_idx_t retire_dest_0;
    word_t    retire_value_0;
    logic     retire_valid_1;
    reg_idx_t retire_dest_1;
    word_t    retire_value_1;
    word_t    read_data;

    // pending instructions in program order, oldest first
    op_e      pend_op       [$];
    reg_idx_t pend_dest     [$];
    word_t    pend_value    [$];
    logic     pend_mispred  [$];
    word_t    pend_redirect [$];
    word_t    model_regs    [`REG_COUNT];

    logic [31:0] rng_state;
    word_t       next_pc;
    int          held_count;
    logic        halt_sent;
    logic        pair_mul;
    logic        squash_due;
    int          error_count;
    int          timeout_count;
    int          retire_count;
    int          squash_count;

    ooo_backend i_dut (
        .clock, .reset,
        .in_valid, .in_op, .in_dest, .in_a, .in_b, .in_pc, .in_predicted_taken,
        .read_addr, .rob_full, .squash, .redirect_pc, .halt,
        .retire_valid_0, .retire_dest_0, .retire_value_0,
        .retire_valid_1, .retire_dest_1, .retire_value_1,
        .read_data
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////
    // stimulus and reference model

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t model_value(input op_e op, input word_t a, input word_t b,
                                          input word_t pc);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_xor:    return a ^ b;
            op_mul:    return product[31:0];
            // link value
            op_branch: return pc + 32'd4;
            default:   return '0;
        endcase
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic enqueue(input op_e op, input reg_idx_t dest, input word_t a, input word_t b,
                           input word_t pc, input logic pred);
        logic taken;
        taken = (a == '0);
        pend_op.push_back(op);
        pend_dest.push_back(dest);
        pend_value.push_back(model_value(op, a, b, pc));
        pend_mispred.push_back((op == op_branch) && (taken != pred));
        pend_redirect.push_back(taken ? b : pc + 32'd4);
        held_count = 1;
    endtask

    task automatic flush_model();
        pend_op.delete();
        pend_dest.delete();
        pend_value.delete();
        pend_mispred.delete();
        pend_redirect.delete();
    endtask

    task automatic retire_one(input int slot, input reg_idx_t dest, input word_t value,
                              output logic mispred, output word_t redirect);
        op_e      op;
        reg_idx_t exp_dest;
        word_t    exp_value;
        mispred  = 1'b0;
        redirect = '0;
        if (pend_op.size() == 0) begin
            $display("slot %0d retired with no instruction pending at %0t", slot, $time);
            error_count++;
            return;
        end
        op        = pend_op.pop_front();
        exp_dest  = pend_dest.pop_front();
        exp_value = pend_value.pop_front();
        mispred   = pend_mispred.pop_front();
        redirect  = pend_redirect.pop_front();
        if (op == op_halt) begin
            $display("halt instruction retired from slot %0d at %0t", slot, $time);
            error_count++;
        end
        check_value(dest, exp_dest, $sformatf("slot %0d destination", slot));
        check_value(value, exp_value, $sformatf("slot %0d value", slot));
        if (exp_dest != '0) begin
            model_regs[exp_dest] = exp_value;
        end
        retire_count++;
    endtask

    // outputs are read at the falling edge, for the retirement at the next rising edge
    task automatic observe_outputs();
        logic  mis0;
        logic  mis1;
        word_t redir0;
        word_t redir1;
        int    rob_count;
        mis0      = 1'b0;
        mis1      = 1'b0;
        redir0    = '0;
        redir1    = '0;
        rob_count = pend_op.size() - held_count;
        check_value(rob_full, rob_count >= `ROB_SIZE - 1, "rob_full against occupancy");
        if (!halt_sent) begin
            check_value(halt, 32'd0, "halt without a halt instruction");
        end
        if (retire_valid_1) begin
            check_value(retire_valid_0, 32'd1, "slot 0 valid alongside slot 1");
        end
        if (retire_valid_0) begin
            retire_one(0, retire_dest_0, retire_value_0, mis0, redir0);
        end
        if (mis0) begin
            check_value(retire_valid_1, 32'd0, "slot 1 behind a mispredicted branch");
        end else if (retire_valid_1) begin
            retire_one(1, retire_dest_1, retire_value_1, mis1, redir1);
        end
        squash_due = mis0 || mis1;
        check_value(squash, squash_due, "squash");
        if (squash_due) begin
            check_value(redirect_pc, mis0 ? redir0 : redir1, "redirect_pc");
            flush_model();
            squash_count++;
        end
    endtask

    // mode 0 random mix, mode 1 mul-then-add pairs, mode 2 mul burst
    task automatic drive_inputs(input logic may_strobe, input int mode);
        logic [31:0] r0;
        logic [31:0] r1;
        int          sel;
        op_e         op;
        word_t       a;
        word_t       b;
        in_valid   = 1'b0;
        held_count = 0;
        if (!may_strobe || rob_full || halt) begin
            return;
        end
        r0 = draw_random();
        if (mode == 0 && r0[2:0] == 3'd0) begin
            return;
        end
        r1  = draw_random();
        sel = int'(r0[15:8]) % 10;
        if (mode == 1) begin
            op       = pair_mul ? op_mul : op_add;
            pair_mul = !pair_mul;
        end else if (mode == 2 || sel >= 7) begin
            op = op_mul;
        end else if (sel == 0) begin
            op = op_branch;
        end else if (sel <= 2) begin
            op = op_add;
        end else if (sel <= 4) begin
            op = op_sub;
        end else begin
            op = op_xor;
        end
        // small a, so zero comes up often
        a = (op == op_branch && r0[20]) ? '0 : word_t'(r0[19:16]);
        b = (op == op_branch) ? {r1[31:2], 2'b00} : r1;
        in_valid           = 1'b1;
        in_op              = op;
        in_dest            = r0[27:24];
        in_a               = a;
        in_b               = b;
        in_pc              = next_pc;
        in_predicted_taken = r0[21];
        // a strobe in a squash cycle is dropped
        if (!squash_due) begin
            enqueue(op, r0[27:24], a, b, next_pc, r0[21]);
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic run_cycle(input logic may_strobe, input int mode);
        @(negedge clock);
        observe_outputs();
        drive_inputs(may_strobe, mode);
    endtask

    ////////////////////////////////////////
    // test phases

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        run_cycle(1'b0, 0);
        while (pend_op.size() != 0 && cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0, 0);
            cycles++;
        end
        if (pend_op.size() != 0) begin
            $display("timeout: %0d instructions still pending after %0d cycles of drain",
                     pend_op.size(), cycles);
            timeout_count++;
        end
    endtask

    task automatic compare_regfile();
        for (int i = 0; i < `REG_COUNT; i++) begin
            read_addr = reg_idx_t'(i);
            run_cycle(1'b0, 0);
            check_value(read_data, (i == 0) ? 32'd0 : model_regs[i],
                        $sformatf("register r%0d", i));
        end
    endtask

    task automatic halt_core();
        int cycles;
        cycles = 0;
        @(negedge clock);
        observe_outputs();
        in_valid           = 1'b1;
        in_op              = op_halt;
        in_dest            = '0;
        in_a               = '0;
        in_b               = '0;
        in_pc              = next_pc;
        in_predicted_taken = 1'b0;
        enqueue(op_halt, '0, '0, '0, next_pc, 1'b0);
        halt_sent = 1'b1;
        run_cycle(1'b0, 0);
        while (!halt && cycles < HALT_LIMIT) begin
            run_cycle(1'b0, 0);
            cycles++;
        end
        if (!halt) begin
            $display("timeout: halt did not rise within %0d cycles", HALT_LIMIT);
            timeout_count++;
        end else begin
            repeat (QUIET_CYCLES) begin
                run_cycle(1'b0, 0);
                check_value(retire_valid_0 || retire_valid_1, 32'd0, "retire after halt");
                check_value(halt, 32'd1, "halt stays high");
            end
        end
    endtask

    initial begin
        reset              = 1'b1;
        in_valid           = 1'b0;
        in_op              = op_add;
        in_dest            = '0;
        in_a               = '0;
        in_b               = '0;
        in_pc              = '0;
        in_predicted_taken = 1'b0;
        read_addr          = '0;
        rng_state          = SEED;
        next_pc            = 32'h0000_1000;
        held_count         = 0;
        halt_sent          = 1'b0;
        pair_mul           = 1'b1;
        squash_due         = 1'b0;
        error_count        = 0;
        timeout_count      = 0;
        retire_count       = 0;
        squash_count       = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_value(squash, 32'd0, "squash after reset");
        check_value(halt, 32'd0, "halt after reset");
        check_value(rob_full, 32'd0, "rob_full after reset");
        check_value(retire_valid_0, 32'd0, "retire_valid_0 after reset");
        check_value(retire_valid_1, 32'd0, "retire_valid_1 after reset");
        repeat (600) run_cycle(1'b1, 0);
        repeat (60) run_cycle(1'b1, 1);
        repeat (60) run_cycle(1'b1, 2);
        drain_pipeline();
        compare_regfile();
        halt_core();
        if (squash_count == 0) begin
            $display("no mispredicted branch reached retirement during the run");
            error_count++;
        end
        $display("retired %0d, squashes %0d, errors %0d, timeouts %0d", retire_count,
                 squash_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/core_pkg.sv
source/dispatch_stage.sv
source/exec_pipe.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/ooo_backend.sv
dv/backend_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module backend_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/Vbackend_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* source/arch_regfile.sv */
`include "core_defines.svh"

module arch_regfile import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    input  logic     write0_valid,
    input  reg_idx_t write0_dest,
    input  word_t    write0_value,
    input  logic     write1_valid,
    input  reg_idx_t write1_dest,
    input  word_t    write1_value,

    input  reg_idx_t read_addr,
    output word_t    read_data
);

    word_t regs [`REG_COUNT];

    // slot 1 is younger, its write lands last
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (write0_valid && (write0_dest != '0)) begin
                regs[write0_dest] <= write0_value;
            end
            if (write1_valid && (write1_dest != '0)) begin
                regs[write1_dest] <= write1_value;
            end
        end
    end

    // r0 hardwired to zero
    assign read_data = (read_addr == '0) ? '0 : regs[read_addr];

endmodule

/* source/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////
// reorder buffer sizing
`define ROB_SIZE       16
`define ROB_TAG_WIDTH  4

////////////////////////////////////////
// datapath and register file
`define XLEN           32
`define REG_COUNT      16
`define REG_IDX_WIDTH  4

// depth of the multiply pipe
`define MUL_LATENCY    3

`endif

/* source/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // operation encodings
    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_xor    = 3'd2,
        op_mul    = 3'd3,
        op_branch = 3'd4,
        op_halt   = 3'd5
    } op_e;

    // index of an entry in the reorder buffer
    typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag_t;

    // architectural register index, r0 reads zero
    typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

    // data word
    typedef logic [`XLEN-1:0] word_t;

endpackage

/* source/dispatch_stage.sv */
module dispatch_stage import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,

    input  logic     in_valid,
    input  op_e      in_op,
    input  reg_idx_t in_dest,
    input  word_t    in_a,
    input  word_t    in_b,
    input  word_t    in_pc,
    input  logic     in_predicted_taken,

    input  rob_tag_t alloc_tag,
    output logic     alloc_valid,
    output op_e      alloc_op,
    output reg_idx_t alloc_dest,
    output word_t    alloc_pc,
    output logic     alloc_predicted_taken,

    output logic     alu_issue_valid,
    output logic     mul_issue_valid,
    output rob_tag_t issue_tag,
    output op_e      issue_op,
    output word_t    issue_a,
    output word_t    issue_b,
    output word_t    issue_pc
);

    logic     held_valid;
    op_e      held_op;
    reg_idx_t held_dest;
    word_t    held_a;
    word_t    held_b;
    word_t    held_pc;
    logic     held_predicted_taken;

    // held instruction, dropped on squash
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        held_op              <= in_op;
        held_dest            <= in_dest;
        held_a               <= in_a;
        held_b               <= in_b;
        held_pc              <= in_pc;
        held_predicted_taken <= in_predicted_taken;
    end

    ////////////////////////////////////////
    // rob allocation at the current tail
    assign alloc_valid           = held_valid;
    assign alloc_op              = held_op;
    assign alloc_dest            = held_dest;
    assign alloc_pc              = held_pc;
    assign alloc_predicted_taken = held_predicted_taken;

    // halt goes nowhere, mul to the long pipe
    assign alu_issue_valid = held_valid && (held_op != op_mul) && (held_op != op_halt);
    assign mul_issue_valid = held_valid && (held_op == op_mul);
    assign issue_tag       = alloc_tag;
    assign issue_op        = held_op;
    assign issue_a         = held_a;
    assign issue_b         = held_b;
    assign issue_pc        = held_pc;

    // sender stops once a halt is on its way in
    assert property (@(posedge clock) disable iff (reset)
        (held_valid && (held_op == op_halt) && !flush) |-> !in_valid);

endmodule

/* source/exec_pipe.sv */
module exec_pipe import core_pkg::*; #(
    parameter int LATENCY = 1
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,

    input  logic     issue_valid,
    input  rob_tag_t issue_tag,
    input  op_e      issue_op,
    input  word_t    issue_a,
    input  word_t    issue_b,
    input  word_t    issue_pc,

    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value,
    output logic     cdb_taken,
    output word_t    cdb_target
);

    logic [LATENCY-1:0] stage_valid;
    logic [LATENCY-1:0] stage_taken;
    rob_tag_t           stage_tag    [LATENCY];
    word_t              stage_value  [LATENCY];
    word_t              stage_target [LATENCY];

    word_t result;
    logic  taken;
    word_t target;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = '0;
        case (issue_op)
            op_add: result = issue_a + issue_b;
            op_sub: result = issue_a - issue_b;
            op_xor: result = issue_a ^ issue_b;
            // low word of the product
            op_mul: result = issue_a * issue_b;
            op_branch: begin
                result = issue_pc + 32'd4;
                taken  = (issue_a == '0);
                target = issue_b;
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue_valid;
            for (int i = 1; i < LATENCY; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        stage_tag[0]    <= issue_tag;
        stage_value[0]  <= result;
        stage_taken[0]  <= taken;
        stage_target[0] <= target;
        for (int i = 1; i < LATENCY; i++) begin
            stage_tag[i]    <= stage_tag[i-1];
            stage_value[i]  <= stage_value[i-1];
            stage_taken[i]  <= stage_taken[i-1];
            stage_target[i] <= stage_target[i-1];
        end
    end

    assign cdb_valid  = stage_valid[LATENCY-1];
    assign cdb_tag    = stage_tag[LATENCY-1];
    assign cdb_value  = stage_value[LATENCY-1];
    assign cdb_taken  = stage_taken[LATENCY-1];
    assign cdb_target = stage_target[LATENCY-1];

    // nothing in flight survives a squash
    assert property (@(posedge clock) disable iff (reset) flush |=> !cdb_valid);

endmodule

/* source/ooo_backend.sv */
`include "core_defines.svh"

module ooo_backend import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    input  logic     in_valid,
    input  op_e      in_op,
    input  reg_idx_t in_dest,
    input  word_t    in_a,
    input  word_t    in_b,
    input  word_t    in_pc,
    input  logic     in_predicted_taken,
    input  reg_idx_t read_addr,

    output logic     rob_full,
    output logic     squash,
    output word_t    redirect_pc,
    output logic     halt,
    output logic     retire_valid_0,
    output reg_idx_t retire_dest_0,
    output word_t    retire_value_0,
    output logic     retire_valid_1,
    output reg_idx_t retire_dest_1,
    output word_t    retire_value_1,
    output word_t    read_data
);

    // dispatch to rob
    logic     alloc_valid;
    op_e      alloc_op;
    reg_idx_t alloc_dest;
    word_t    alloc_pc;
    logic     alloc_predicted_taken;
    rob_tag_t alloc_tag;

    // dispatch to pipes
    logic     alu_issue_valid;
    logic     mul_issue_valid;
    rob_tag_t issue_tag;
    op_e      issue_op;
    word_t    issue_a;
    word_t    issue_b;
    word_t    issue_pc;

    // completion buses, 0 from alu and 1 from mul
    logic     cdb0_valid;
    rob_tag_t cdb0_tag;
    word_t    cdb0_value;
    logic     cdb0_taken;
    word_t    cdb0_target;
    logic     cdb1_valid;
    rob_tag_t cdb1_tag;
    word_t    cdb1_value;
    logic     cdb1_taken;
    word_t    cdb1_target;

    dispatch_stage i_dispatch (
        .clock, .reset, .flush(squash),
        .in_valid, .in_op, .in_dest, .in_a, .in_b, .in_pc, .in_predicted_taken,
        .alloc_tag, .alloc_valid, .alloc_op, .alloc_dest, .alloc_pc, .alloc_predicted_taken,
        .alu_issue_valid, .mul_issue_valid,
        .issue_tag, .issue_op, .issue_a, .issue_b, .issue_pc
    );

    exec_pipe #(.LATENCY(1)) i_alu_pipe (
        .clock, .reset, .flush(squash),
        .issue_valid(alu_issue_valid), .issue_tag, .issue_op, .issue_a, .issue_b, .issue_pc,
        .cdb_valid(cdb0_valid), .cdb_tag(cdb0_tag), .cdb_value(cdb0_value),
        .cdb_taken(cdb0_taken), .cdb_target(cdb0_target)
    );

    exec_pipe #(.LATENCY(`MUL_LATENCY)) i_mul_pipe (
        .clock, .reset, .flush(squash),
        .issue_valid(mul_issue_valid), .issue_tag, .issue_op, .issue_a, .issue_b, .issue_pc,
        .cdb_valid(cdb1_valid), .cdb_tag(cdb1_tag), .cdb_value(cdb1_value),
        .cdb_taken(cdb1_taken), .cdb_target(cdb1_target)
    );

    reorder_buffer i_rob (
        .clock, .reset,
        .alloc_valid, .alloc_op, .alloc_dest, .alloc_pc, .alloc_predicted_taken, .alloc_tag,
        .cdb0_valid, .cdb0_tag, .cdb0_value, .cdb0_taken, .cdb0_target,
        .cdb1_valid, .cdb1_tag, .cdb1_value, .cdb1_taken, .cdb1_target,
        .rob_full, .squash, .redirect_pc, .halt,
        .retire_valid_0, .retire_dest_0, .retire_value_0,
        .retire_valid_1, .retire_dest_1, .retire_value_1
    );

    arch_regfile i_regfile (
        .clock, .reset,
        .write0_valid(retire_valid_0), .write0_dest(retire_dest_0),
        .write0_value(retire_value_0),
        .write1_valid(retire_valid_1), .write1_dest(retire_dest_1),
        .write1_value(retire_value_1),
        .read_addr, .read_data
    );

endmodule

/* source/reorder_buffer.sv */
`include "core_defines.svh"

module reorder_buffer import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    input  logic     alloc_valid,
    input  op_e      alloc_op,
    input  reg_idx_t alloc_dest,
    input  word_t    alloc_pc,
    input  logic     alloc_predicted_taken,
    output rob_tag_t alloc_tag,

    input  logic     cdb0_valid,
    input  rob_tag_t cdb0_tag,
    input  word_t    cdb0_value,
    input  logic     cdb0_taken,
    input  word_t    cdb0_target,

    input  logic     cdb1_valid,
    input  rob_tag_t cdb1_tag,
    input  word_t    cdb1_value,
    input  logic     cdb1_taken,
    input  word_t    cdb1_target,

    output logic     rob_full,
    output logic     squash,
    output word_t    redirect_pc,
    output logic     halt,

    output logic     retire_valid_0,
    output reg_idx_t retire_dest_0,
    output word_t    retire_value_0,
    output logic     retire_valid_1,
    output reg_idx_t retire_dest_1,
    output word_t    retire_value_1
);

    typedef logic [`ROB_TAG_WIDTH:0] count_t;

    rob_tag_t head;
    rob_tag_t head_plus_1;
    rob_tag_t tail;
    count_t   count;
    logic     empty;
    logic     halt_q;
    logic     squash_0;
    logic     squash_1;
    word_t    redirect_0;
    word_t    redirect_1;

    // entry state
    logic [`ROB_SIZE-1:0] ent_valid;
    logic [`ROB_SIZE-1:0] ent_ready;
    op_e                  ent_op        [`ROB_SIZE];
    reg_idx_t             ent_dest      [`ROB_SIZE];
    word_t                ent_value     [`ROB_SIZE];
    word_t                ent_pc        [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] ent_pred;
    logic [`ROB_SIZE-1:0] ent_taken;
    word_t                ent_target    [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] ent_mispred;

    assign head_plus_1 = head + 1'b1;
    assign empty       = (count == '0);
    // one slot held back for the dispatch register
    assign rob_full    = (count >= count_t'(`ROB_SIZE - 1));
    assign alloc_tag   = tail;
    assign halt        = halt_q;

    ////////////////////////////////////////
    // retire selection
    assign retire_valid_0 = !empty && ent_ready[head];
    assign retire_valid_1 = retire_valid_0 && !ent_mispred[head] && (ent_op[head] != op_halt)
                         && ent_valid[head_plus_1] && ent_ready[head_plus_1]
                         && (ent_op[head_plus_1] != op_halt);

    assign retire_dest_0  = ent_dest[head];
    assign retire_value_0 = ent_value[head];
    assign retire_dest_1  = ent_dest[head_plus_1];
    assign retire_value_1 = ent_value[head_plus_1];

    // mispredicts still retire for their link value
    assign squash_0   = retire_valid_0 && ent_mispred[head];
    assign squash_1   = retire_valid_1 && ent_mispred[head_plus_1];
    assign squash     = squash_0 || squash_1;
    assign redirect_0 = ent_taken[head] ? ent_target[head] : ent_pc[head] + 32'd4;
    assign redirect_1 = ent_taken[head_plus_1] ? ent_target[head_plus_1]
                                               : ent_pc[head_plus_1] + 32'd4;
    assign redirect_pc = squash_0 ? redirect_0 : redirect_1;

    ////////////////////////////////////////
    // pointers, valid and ready
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_ready <= '0;
        end else begin
            if (alloc_valid) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (retire_valid_0) begin
                ent_valid[head] <= 1'b0;
            end
            if (retire_valid_1) begin
                ent_valid[head_plus_1] <= 1'b0;
                head                   <= head_plus_1 + 1'b1;
            end else if (retire_valid_0) begin
                head <= head_plus_1;
            end
            if (cdb0_valid && ent_valid[cdb0_tag]) begin
                ent_ready[cdb0_tag] <= 1'b1;
            end
            if (cdb1_valid && ent_valid[cdb1_tag]) begin
                ent_ready[cdb1_tag] <= 1'b1;
            end
            count <= count + count_t'(alloc_valid) - count_t'(retire_valid_0)
                   - count_t'(retire_valid_1);
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            ent_op[tail]      <= alloc_op;
            ent_dest[tail]    <= alloc_dest;
            ent_pc[tail]      <= alloc_pc;
            ent_pred[tail]    <= alloc_predicted_taken;
            ent_mispred[tail] <= 1'b0;
        end
        if (cdb0_valid && ent_valid[cdb0_tag]) begin
            ent_value[cdb0_tag]   <= cdb0_value;
            ent_taken[cdb0_tag]   <= cdb0_taken;
            ent_target[cdb0_tag]  <= cdb0_target;
            ent_mispred[cdb0_tag] <= (ent_op[cdb0_tag] == op_branch)
                                  && (cdb0_taken != ent_pred[cdb0_tag]);
        end
        if (cdb1_valid && ent_valid[cdb1_tag]) begin
            ent_value[cdb1_tag]   <= cdb1_value;
            ent_taken[cdb1_tag]   <= cdb1_taken;
            ent_target[cdb1_tag]  <= cdb1_target;
            ent_mispred[cdb1_tag] <= (ent_op[cdb1_tag] == op_branch)
                                  && (cdb1_taken != ent_pred[cdb1_tag]);
        end
    end

    // halt is never issued, so it waits at the head unready
    always_ff @(posedge clock) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (!empty && ent_valid[head] && (ent_op[head] == op_halt)) begin
            halt_q <= 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        alloc_valid |-> (count < count_t'(`ROB_SIZE)));

    // pipes never complete the same entry together
    assert property (@(posedge clock) disable iff (reset)
        !(cdb0_valid && cdb1_valid && (cdb0_tag == cdb1_tag)));

endmodule
